/* flist.f */
+incdir+src
src/lchk_pkg.sv
src/lchk_symbol_decode.sv
src/lchk_frame_checker.sv
src/lchk_apb_regs.sv
src/lchk_top.sv
verification/lchk_asserts.sv
verification/lchk_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the link checker testbench with Verilator and runs it
# the result is taken from the log, a missing pass line is a failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module lchk_tb -f flist.f -o lchk_sim

./obj_dir/lchk_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: test passed"
    exit 0
else
    echo "run_sim: test failed, see sim.log"
    exit 1
fi

/* verification/lchk_tb.sv */
// random test frames on four lanes checked against a lane model
// lanes idle on sync words between phases and registers are read over apb
// stream and bind code assume the lane count of 4
`timescale 1ns/1ps
`default_nettype none
`include "lchk_settings.svh"

module lchk_tb;

    localparam int N              = `LCHK_NUM_LANES;
    localparam int HALF_PERIOD    = 20;
    localparam int DEPTH          = 1024;
    localparam int SETTLE         = 8;
    localparam int FRAME_WORDS    = 40;
    localparam int TOTAL_FRAMES   = 63;
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * FRAME_WORDS + 1500;
    localparam logic [17:0] IDLE_SYM = {`LCHK_SYNC_KFLAGS, `LCHK_SYNC_WORD};

    logic            clk = 1'b0;
    logic            arst_n;
    logic [N*16-1:0] rxd;
    logic [N-1:0]    rkmsb;
    logic [N-1:0]    rklsb;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [7:0]      paddr;
    logic [31:0]     pwdata;
    logic [31:0]     prdata;
    logic            pready;
    logic            pslverr;

    logic [31:0] rng_state = 32'h8c23;
    logic [17:0] stream [N][DEPTH];
    int          stream_len [N];
    logic [15:0] m_exp [N];
    logic [15:0] m_good [N];
    logic [15:0] m_errs [N];
    logic [3:0]  m_last [N];
    logic [N-1:0] m_ctrl;
    int checks = 0;
    int errors = 0;
    int cycle_cnt = 0;

    always #HALF_PERIOD clk = ~clk;

    lchk_top lchk_top_inst (
        .clk       (clk),
        .i_arst_n  (arst_n),
        .i_rxd     (rxd),
        .i_rkmsb   (rkmsb),
        .i_rklsb   (rklsb),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    bind lchk_frame_checker lchk_asserts u_asserts (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_en       (i_en),
        .i_good     (o_good),
        .i_err      (o_err),
        .i_err_code (o_err_code)
    );

    function automatic int unsigned rand_below(input int unsigned n);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return (rng_state >> 12) % n;
    endfunction

    // code 1 or 3..11 as the checker never raises code 2
    function automatic int pick_fault();
        int f;
        f = rand_below(10);
        return (f == 0) ? 1 : f + 2;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // apb master
    ////////////////////////////////////////////////////////////
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // sample mid access phase where outputs are settled
        #(HALF_PERIOD / 2);
        rdata  = prdata;
        slverr = pslverr;
        check_value("pready", 32'(pready), 32'h1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b1, addr, data, rdata, slverr);
        check_value("pslverr", 32'(slverr), 32'h0);
    endtask

    task automatic read_check(input string name, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rdata;
        logic        slverr;
        apb_access(1'b0, addr, 32'h0, rdata, slverr);
        check_value(name, rdata, exp);
        check_value("pslverr", 32'(slverr), 32'h0);
    endtask

    task automatic check_regs();
        logic [7:0] base;
        read_check("ctrl", `LCHK_ADDR_CTRL, 32'(m_ctrl));
        for (int n = 0; n < N; n++) begin
            base = 8'(`LCHK_ADDR_LANE_BASE + n * `LCHK_LANE_STRIDE);
            read_check($sformatf("lane%0d_good", n), base + `LCHK_OFF_GOOD, 32'(m_good[n]));
            read_check($sformatf("lane%0d_errs", n), base + `LCHK_OFF_ERRS, 32'(m_errs[n]));
            read_check($sformatf("lane%0d_last", n), base + `LCHK_OFF_LAST, 32'(m_last[n]));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // frame builder and lane model
    ////////////////////////////////////////////////////////////
    task automatic push_word(input int lane, input logic [1:0] k, input logic [15:0] w);
        stream[lane][stream_len[lane]] = {k, w};
        stream_len[lane]++;
    endtask

    task automatic update_model(input int lane, input int fault, input logic [15:0] num);
        if (m_ctrl[lane]) begin
            if (fault != 0) begin
                if (m_errs[lane] != 16'hffff) m_errs[lane] = m_errs[lane] + 16'd1;
                m_last[lane] = 4'(fault);
            end
            // a stray word before SOF still lets the frame through
            if (fault == 0 || fault == 1) begin
                m_good[lane] = m_good[lane] + 16'd1;
                m_exp[lane]  = m_exp[lane] + 16'd1;
            end else if (fault == 6) begin
                m_exp[lane] = num + 16'd1;
            end
        end
    endtask

    task automatic build_frame(input int lane, input int fault);
        int unsigned nbytes;
        int unsigned bad_idx;
        logic [15:0] num;
        logic [15:0] sum;
        logic [15:0] w;
        logic [1:0]  kf;
        repeat (1 + rand_below(4)) push_word(lane, `LCHK_SYNC_KFLAGS, `LCHK_SYNC_WORD);
        if (fault == 1) begin
            push_word(lane, 2'b00, 16'h0bad);
            push_word(lane, `LCHK_SYNC_KFLAGS, `LCHK_SYNC_WORD);
        end
        nbytes = 2 * rand_below(21);
        if ((fault == 8 || fault == 11) && nbytes == 0) nbytes = 2;
        bad_idx = (nbytes > 0) ? rand_below(nbytes / 2) : 0;
        num = m_exp[lane];
        if (fault == 6) num = m_exp[lane] + 16'(1 + rand_below(5));
        push_word(lane, `LCHK_FRAME_KFLAGS, `LCHK_SOF_WORD);
        w = `LCHK_HEAD0 ^ ((fault == 3) ? 16'h0010 : 16'h0000);
        push_word(lane, 2'b00, w);
        sum = w;
        w = `LCHK_HEAD1 ^ ((fault == 4) ? 16'h0200 : 16'h0000);
        push_word(lane, 2'b00, w);
        sum = sum + w;
        w = `LCHK_FILE_END ^ ((fault == 5) ? 16'h0001 : 16'h0000);
        push_word(lane, 2'b00, w);
        sum = sum + w;
        push_word(lane, 2'b00, num);
        sum = sum + num;
        w = 16'(nbytes) | ((fault == 7) ? 16'h0001 : 16'h0000);
        push_word(lane, 2'b00, w);
        sum = sum + w;
        for (int unsigned i = 0; i < nbytes / 2; i++) begin
            w  = 16'(i) ^ ((fault == 8 && i == bad_idx) ? 16'h8000 : 16'h0000);
            kf = (fault == 11 && i == bad_idx) ? 2'b10 : 2'b00;
            push_word(lane, kf, w);
            sum = sum + w;
        end
        push_word(lane, 2'b00, sum ^ ((fault == 9) ? 16'h0001 : 16'h0000));
        if (fault == 10) begin
            push_word(lane, 2'b00, 16'h0000);
        end else begin
            push_word(lane, `LCHK_FRAME_KFLAGS, `LCHK_EOF_WORD);
        end
        update_model(lane, fault, num);
    endtask

    task automatic build_phase(input int frames, input int fault_pct);
        int fault;
        for (int n = 0; n < N; n++) begin
            stream_len[n] = 0;
            for (int f = 0; f < frames; f++) begin
                fault = (rand_below(100) < fault_pct) ? pick_fault() : 0;
                build_frame(n, fault);
            end
        end
    endtask

    task automatic drive_lane(input int lane, input logic [17:0] sym);
        rxd[lane*16 +: 16] = sym[15:0];
        rkmsb[lane]        = sym[17];
        rklsb[lane]        = sym[16];
    endtask

    // lanes run in lockstep and short streams pad with sync words
    task automatic drive_streams();
        int longest;
        longest = 0;
        for (int n = 0; n < N; n++) begin
            if (stream_len[n] > longest) longest = stream_len[n];
        end
        for (int c = 0; c < longest + SETTLE; c++) begin
            @(negedge clk);
            for (int n = 0; n < N; n++) begin
                drive_lane(n, (c < stream_len[n]) ? stream[n][c] : IDLE_SYM);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0]  rdata;
        logic         slverr;
        logic [N-1:0] pair;
        int           lane_sel;
        int unsigned  afails;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        m_ctrl  = '0;
        for (int n = 0; n < N; n++) begin
            drive_lane(n, IDLE_SYM);
            stream_len[n] = 0;
            m_exp[n]      = '0;
            m_good[n]     = '0;
            m_errs[n]     = '0;
            m_last[n]     = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // clean frames on every lane
        m_ctrl = 4'hf;
        write_reg(`LCHK_ADDR_CTRL, 32'(m_ctrl));
        build_phase(20, 0);
        drive_streams();
        check_regs();

        // single faults in about half the frames
        build_phase(20, 50);
        drive_streams();
        check_regs();

        // skipped frame number followed by two in sequence
        for (int n = 0; n < N; n++) begin
            stream_len[n] = 0;
            build_frame(n, 6);
            build_frame(n, 0);
            build_frame(n, 0);
        end
        drive_streams();
        check_regs();

        // one lane switched off while frames arrive
        lane_sel = rand_below(4);
        m_ctrl   = 4'hf & ~(4'b0001 << lane_sel);
        write_reg(`LCHK_ADDR_CTRL, 32'(m_ctrl));
        build_phase(10, 25);
        drive_streams();
        check_regs();
        m_ctrl = 4'hf;
        write_reg(`LCHK_ADDR_CTRL, 32'(m_ctrl));
        build_phase(5, 0);
        drive_streams();
        check_regs();

        // clear two lanes so their numbering restarts at 0
        lane_sel = rand_below(4);
        pair     = (4'b0001 << lane_sel) | (4'b0001 << ((lane_sel + 1 + rand_below(3)) % 4));
        write_reg(`LCHK_ADDR_CLEAR, 32'(pair));
        for (int n = 0; n < N; n++) begin
            if (pair[n]) begin
                m_exp[n]  = '0;
                m_good[n] = '0;
                m_errs[n] = '0;
                m_last[n] = '0;
            end
        end
        check_regs();
        build_phase(5, 0);
        drive_streams();
        check_regs();

        // ctrl readback and unmapped accesses
        m_ctrl = 4'(rand_below(16));
        write_reg(`LCHK_ADDR_CTRL, 32'(m_ctrl));
        read_check("ctrl", `LCHK_ADDR_CTRL, 32'(m_ctrl));
        apb_access(1'b1, 8'h14, 32'hffff_ffff, rdata, slverr);
        check_value("pslverr", 32'(slverr), 32'h1);
        apb_access(1'b0, 8'h5c, 32'h0, rdata, slverr);
        check_value("pslverr", 32'(slverr), 32'h1);
        check_regs();

        afails = lchk_top_inst.g_lane[0].u_chk.u_asserts.fails
               + lchk_top_inst.g_lane[1].u_chk.u_asserts.fails
               + lchk_top_inst.g_lane[2].u_chk.u_asserts.fails
               + lchk_top_inst.g_lane[3].u_chk.u_asserts.fails;
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/lchk_asserts.sv */
// pulse rules for one frame checker, bound to every instance
// a result pulse depends on the enable of the cycle before
`timescale 1ns/1ps
`default_nettype none

module lchk_asserts (
    input wire       clk,
    input wire       i_arst_n,
    input wire       i_en,
    input wire       i_good,
    input wire       i_err,
    input wire [3:0] i_err_code
);

    // assertion failure count
    int unsigned fails = 0;

    a_one_result: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_good && i_err))
    else begin
        $error("good and error pulses are high in the same cycle");
        fails++;
    end

    a_err_code: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_err |-> (i_err_code != 4'd0))
    else begin
        $error("error pulse carries code zero");
        fails++;
    end

    a_quiet_when_off: assert property (@(posedge clk) disable iff (!i_arst_n)
        !i_en |=> !(i_good || i_err))
    else begin
        $error("result pulse from a disabled lane");
        fails++;
    end

endmodule

`default_nettype wire

/* src/lchk_top.sv */
// four-lane rx link checker for TLK2711 test mode
// a rx word shows up as a pulse 2 cycles later, in the registers after 3
// no back-pressure on the lanes, all lanes start disabled
`timescale 1ns/1ps
`default_nettype none
`include "lchk_settings.svh"

module lchk_top (
    input  wire                                     clk,
    input  wire                                     i_arst_n,
    input  wire  [`LCHK_NUM_LANES*`LCHK_WORD_W-1:0] i_rxd,
    input  wire  [`LCHK_NUM_LANES-1:0]              i_rkmsb,
    input  wire  [`LCHK_NUM_LANES-1:0]              i_rklsb,
    input  wire                                     i_psel,
    input  wire                                     i_penable,
    input  wire                                     i_pwrite,
    input  wire  [`LCHK_APB_AW-1:0]                 i_paddr,
    input  wire  [31:0]                             i_pwdata,
    output logic [31:0]                             o_prdata,
    output logic                                    o_pready,
    output logic                                    o_pslverr
);

    localparam int N  = `LCHK_NUM_LANES;
    localparam int W  = `LCHK_WORD_W;
    localparam int KW = lchk_pkg::KIND_W;

    logic [N*W-1:0]  word_bus;
    logic [N*KW-1:0] kind_bus;
    logic [N-1:0]    good;
    logic [N-1:0]    err;
    logic [N*4-1:0]  err_code_bus;
    logic [N-1:0]    lane_en;
    logic [N-1:0]    lane_clr;

    lchk_symbol_decode u_decode (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_rxd    (i_rxd),
        .i_rkmsb  (i_rkmsb),
        .i_rklsb  (i_rklsb),
        .o_word   (word_bus),
        .o_kind   (kind_bus)
    );

    // one checker per lane
    for (genvar n = 0; n < N; n++) begin : g_lane
        lchk_frame_checker u_chk (
            .clk        (clk),
            .i_arst_n   (i_arst_n),
            .i_en       (lane_en[n]),
            .i_clr      (lane_clr[n]),
            .i_word     (word_bus[n*W +: W]),
            .i_kind     (lchk_pkg::sym_kind_t'(kind_bus[n*KW +: KW])),
            .o_good     (good[n]),
            .o_err      (err[n]),
            .o_err_code (err_code_bus[n*4 +: 4])
        );
    end

    lchk_apb_regs u_regs (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .i_good     (good),
        .i_err      (err),
        .i_err_code (err_code_bus),
        .o_lane_en  (lane_en),
        .o_lane_clr (lane_clr)
    );

endmodule

`default_nettype wire

/* src/lchk_apb_regs.sv */
// apb slave with zero wait states, pready is tied high
// CTRL holds the lane enables, a write to CLEAR strobes per-lane clear
// error counts saturate at ffff, good counts wrap
// unmapped addresses answer with pslverr and change nothing
`timescale 1ns/1ps
`default_nettype none
`include "lchk_settings.svh"

module lchk_apb_regs (
    input  wire                                clk,
    input  wire                                i_arst_n,
    input  wire                                i_psel,
    input  wire                                i_penable,
    input  wire                                i_pwrite,
    input  wire  [`LCHK_APB_AW-1:0]            i_paddr,
    input  wire  [31:0]                        i_pwdata,
    output logic [31:0]                        o_prdata,
    output logic                               o_pready,
    output logic                               o_pslverr,
    input  wire  [`LCHK_NUM_LANES-1:0]         i_good,
    input  wire  [`LCHK_NUM_LANES-1:0]         i_err,
    input  wire  [`LCHK_NUM_LANES*4-1:0]       i_err_code,
    output logic [`LCHK_NUM_LANES-1:0]         o_lane_en,
    output logic [`LCHK_NUM_LANES-1:0]         o_lane_clr
);

    localparam int N = `LCHK_NUM_LANES;

    lchk_pkg::cnt_t      good_cnt [N];
    lchk_pkg::cnt_t      err_cnt  [N];
    lchk_pkg::err_code_t last_err [N];

    logic access;
    logic hit;
    logic wr;

    function automatic logic [`LCHK_APB_AW-1:0] lane_addr(input int lane, input int off);
        return `LCHK_APB_AW'(`LCHK_ADDR_LANE_BASE + lane * `LCHK_LANE_STRIDE + off);
    endfunction

    assign access   = i_psel && i_penable;
    assign wr       = access && i_pwrite && hit;
    assign o_pready = 1'b1;

    ////////////////////////////////////////////////////////////
    // address decode and read mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        o_prdata = '0;
        hit      = 1'b0;
        if (i_paddr == `LCHK_ADDR_CTRL) begin
            hit      = 1'b1;
            o_prdata = 32'(o_lane_en);
        end else if (i_paddr == `LCHK_ADDR_CLEAR) begin
            // write-only strobe, reads as zero
            hit = 1'b1;
        end
        for (int n = 0; n < N; n++) begin
            if (i_paddr == lane_addr(n, `LCHK_OFF_GOOD)) begin
                hit      = 1'b1;
                o_prdata = 32'(good_cnt[n]);
            end else if (i_paddr == lane_addr(n, `LCHK_OFF_ERRS)) begin
                hit      = 1'b1;
                o_prdata = 32'(err_cnt[n]);
            end else if (i_paddr == lane_addr(n, `LCHK_OFF_LAST)) begin
                hit      = 1'b1;
                o_prdata = 32'(last_err[n]);
            end
        end
        o_pslverr = access && !hit;
    end

    // CTRL and the clear strobe
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_lane_en  <= '0;
            o_lane_clr <= '0;
        end else begin
            o_lane_clr <= '0;
            if (wr && i_paddr == `LCHK_ADDR_CTRL) o_lane_en <= i_pwdata[N-1:0];
            if (wr && i_paddr == `LCHK_ADDR_CLEAR) o_lane_clr <= i_pwdata[N-1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // per-lane result counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int n = 0; n < N; n++) begin
                good_cnt[n] <= '0;
                err_cnt[n]  <= '0;
                last_err[n] <= lchk_pkg::ERR_NONE;
            end
        end else begin
            for (int n = 0; n < N; n++) begin
                if (o_lane_clr[n]) begin
                    good_cnt[n] <= '0;
                    err_cnt[n]  <= '0;
                    last_err[n] <= lchk_pkg::ERR_NONE;
                end else begin
                    if (i_good[n]) good_cnt[n] <= good_cnt[n] + 1'b1;
                    if (i_err[n]) begin
                        last_err[n] <= i_err_code[n*4 +: 4];
                        if (err_cnt[n] != '1) err_cnt[n] <= err_cnt[n] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/lchk_frame_checker.sv */
// test frame checker for one lane
// pulses o_good or o_err one cycle after the deciding word
// any error drops back to HUNT, the link has to resync first
// while disabled the FSM sits in HUNT and the expected number is kept
`timescale 1ns/1ps
`default_nettype none
`include "lchk_settings.svh"

module lchk_frame_checker (
    input  wire                        clk,
    input  wire                        i_arst_n,
    input  wire                        i_en,
    input  wire                        i_clr,
    input  wire  [`LCHK_WORD_W-1:0]    i_word,
    input  wire  lchk_pkg::sym_kind_t  i_kind,
    output logic                       o_good,
    output logic                       o_err,
    output lchk_pkg::err_code_t        o_err_code
);

    lchk_pkg::chk_state_t state;
    lchk_pkg::chk_state_t nxt_state;
    lchk_pkg::err_code_t  nxt_err;
    logic                 frame_ok;
    logic                 data_field;
    logic                 num_bad;

    lchk_pkg::word_t exp_num;
    lchk_pkg::word_t data_exp;
    lchk_pkg::word_t rem;
    lchk_pkg::word_t csum;

    assign data_field = state inside {lchk_pkg::ST_HEAD0, lchk_pkg::ST_HEAD1,
                                      lchk_pkg::ST_FILE_END, lchk_pkg::ST_FRAME_NUM,
                                      lchk_pkg::ST_LENGTH, lchk_pkg::ST_DATA,
                                      lchk_pkg::ST_CHECKSUM};

    assign num_bad = (state == lchk_pkg::ST_FRAME_NUM) && (i_kind == lchk_pkg::KIND_DATA)
                     && (i_word != exp_num);

    ////////////////////////////////////////////////////////////
    // next state and field checks
    ////////////////////////////////////////////////////////////
    always_comb begin
        nxt_state = state;
        nxt_err   = lchk_pkg::ERR_NONE;
        frame_ok  = 1'b0;
        if (data_field && i_kind != lchk_pkg::KIND_DATA) begin
            nxt_err = lchk_pkg::ERR_KCHAR;
        end else begin
            case (state)
                lchk_pkg::ST_HUNT: begin
                    if (i_kind == lchk_pkg::KIND_SYNC) nxt_state = lchk_pkg::ST_SYNCED;
                end
                lchk_pkg::ST_SYNCED: begin
                    if (i_kind == lchk_pkg::KIND_SOF) begin
                        nxt_state = lchk_pkg::ST_HEAD0;
                    end else if (i_kind != lchk_pkg::KIND_SYNC) begin
                        nxt_err = lchk_pkg::ERR_SYNC;
                    end
                end
                lchk_pkg::ST_HEAD0: begin
                    nxt_state = lchk_pkg::ST_HEAD1;
                    if (i_word != `LCHK_HEAD0) nxt_err = lchk_pkg::ERR_HEAD0;
                end
                lchk_pkg::ST_HEAD1: begin
                    nxt_state = lchk_pkg::ST_FILE_END;
                    if (i_word != `LCHK_HEAD1) nxt_err = lchk_pkg::ERR_HEAD1;
                end
                lchk_pkg::ST_FILE_END: begin
                    nxt_state = lchk_pkg::ST_FRAME_NUM;
                    if (i_word != `LCHK_FILE_END) nxt_err = lchk_pkg::ERR_FILE_END;
                end
                lchk_pkg::ST_FRAME_NUM: begin
                    nxt_state = lchk_pkg::ST_LENGTH;
                    if (num_bad) nxt_err = lchk_pkg::ERR_FRAME_NUM;
                end
                lchk_pkg::ST_LENGTH: begin
                    if (i_word[0]) begin
                        nxt_err = lchk_pkg::ERR_ODD_LEN;
                    end else if (i_word == '0) begin
                        // empty frame, checksum follows at once
                        nxt_state = lchk_pkg::ST_CHECKSUM;
                    end else begin
                        nxt_state = lchk_pkg::ST_DATA;
                    end
                end
                lchk_pkg::ST_DATA: begin
                    if (i_word != data_exp) begin
                        nxt_err = lchk_pkg::ERR_DATA;
                    end else if (rem == lchk_pkg::word_t'(1)) begin
                        nxt_state = lchk_pkg::ST_CHECKSUM;
                    end
                end
                lchk_pkg::ST_CHECKSUM: begin
                    nxt_state = lchk_pkg::ST_EOF;
                    if (i_word != csum) nxt_err = lchk_pkg::ERR_CSUM;
                end
                lchk_pkg::ST_EOF: begin
                    if (i_kind == lchk_pkg::KIND_EOF) begin
                        frame_ok  = 1'b1;
                        nxt_state = lchk_pkg::ST_SYNCED;
                    end else begin
                        nxt_err = lchk_pkg::ERR_EOF;
                    end
                end
                default: nxt_state = lchk_pkg::ST_HUNT;
            endcase
        end
        if (nxt_err != lchk_pkg::ERR_NONE) nxt_state = lchk_pkg::ST_HUNT;
    end

    ////////////////////////////////////////////////////////////
    // control state and result pulses
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state      <= lchk_pkg::ST_HUNT;
            exp_num    <= '0;
            o_good     <= 1'b0;
            o_err      <= 1'b0;
            o_err_code <= lchk_pkg::ERR_NONE;
        end else begin
            state      <= i_en ? nxt_state : lchk_pkg::ST_HUNT;
            o_good     <= i_en && frame_ok;
            o_err      <= i_en && (nxt_err != lchk_pkg::ERR_NONE);
            o_err_code <= i_en ? nxt_err : lchk_pkg::ERR_NONE;
            if (i_clr) begin
                exp_num <= '0;
            end else if (i_en && frame_ok) begin
                exp_num <= exp_num + 1'b1;
            end else if (i_en && num_bad) begin
                // resync the sequence to what the sender uses
                exp_num <= i_word + 1'b1;
            end
        end
    end

    // data pattern, remaining words and running checksum
    always_ff @(posedge clk) begin
        if (state == lchk_pkg::ST_LENGTH) begin
            rem      <= {1'b0, i_word[`LCHK_WORD_W-1:1]};
            data_exp <= '0;
        end else if (state == lchk_pkg::ST_DATA) begin
            rem      <= rem - 1'b1;
            data_exp <= data_exp + 1'b1;
        end
        if (state == lchk_pkg::ST_HEAD0) begin
            csum <= i_word;
        end else if (data_field && state != lchk_pkg::ST_CHECKSUM) begin
            csum <= csum + i_word;
        end
    end

endmodule

`default_nettype wire

/* src/lchk_symbol_decode.sv */
// input register stage for all lanes, adds one cycle
// the only place where sync, SOF and EOF are recognised
// any flagged word that is not one of those comes out as BADK
`timescale 1ns/1ps
`default_nettype none
`include "lchk_settings.svh"

module lchk_symbol_decode (
    input  wire                                         clk,
    input  wire                                         i_arst_n,
    input  wire  [`LCHK_NUM_LANES*`LCHK_WORD_W-1:0]     i_rxd,
    input  wire  [`LCHK_NUM_LANES-1:0]                  i_rkmsb,
    input  wire  [`LCHK_NUM_LANES-1:0]                  i_rklsb,
    output logic [`LCHK_NUM_LANES*`LCHK_WORD_W-1:0]     o_word,
    output logic [`LCHK_NUM_LANES*lchk_pkg::KIND_W-1:0] o_kind
);

    localparam int W  = `LCHK_WORD_W;
    localparam int KW = lchk_pkg::KIND_W;

    function automatic lchk_pkg::sym_kind_t classify(
        input lchk_pkg::word_t word,
        input logic [1:0]      kflags
    );
        lchk_pkg::sym_kind_t kind;
        if (kflags == 2'b00) begin
            kind = lchk_pkg::KIND_DATA;
        end else if (kflags == `LCHK_SYNC_KFLAGS && word == `LCHK_SYNC_WORD) begin
            kind = lchk_pkg::KIND_SYNC;
        end else if (kflags == `LCHK_FRAME_KFLAGS && word == `LCHK_SOF_WORD) begin
            kind = lchk_pkg::KIND_SOF;
        end else if (kflags == `LCHK_FRAME_KFLAGS && word == `LCHK_EOF_WORD) begin
            kind = lchk_pkg::KIND_EOF;
        end else begin
            kind = lchk_pkg::KIND_BADK;
        end
        return kind;
    endfunction

    // raw words, passed on unchanged
    always_ff @(posedge clk) begin
        o_word <= i_rxd;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            // every lane reads as plain data
            o_kind <= '0;
        end else begin
            for (int n = 0; n < `LCHK_NUM_LANES; n++) begin
                o_kind[n*KW +: KW] <= classify(i_rxd[n*W +: W], {i_rkmsb[n], i_rklsb[n]});
            end
        end
    end

endmodule

`default_nettype wire

/* src/lchk_pkg.sv */
// types shared by the link checker blocks
// frame numbers and lengths travel as plain 16-bit words
`default_nettype none
`include "lchk_settings.svh"

package lchk_pkg;

    typedef logic [`LCHK_WORD_W-1:0] word_t;
    typedef logic [3:0]              err_code_t;
    typedef logic [15:0]             cnt_t;

    localparam int KIND_W = 3;

    // symbol kinds out of the decoder, DATA means no k flag
    typedef enum logic [KIND_W-1:0] {
        KIND_DATA,
        KIND_SYNC,
        KIND_SOF,
        KIND_EOF,
        KIND_BADK
    } sym_kind_t;

    typedef enum logic [3:0] {
        ST_HUNT,
        ST_SYNCED,
        ST_HEAD0,
        ST_HEAD1,
        ST_FILE_END,
        ST_FRAME_NUM,
        ST_LENGTH,
        ST_DATA,
        ST_CHECKSUM,
        ST_EOF
    } chk_state_t;

    // error codes, code 2 (bad SOF) is reserved since a stray word
    // while synced already reports code 1
    localparam err_code_t ERR_NONE      = 4'd0;
    localparam err_code_t ERR_SYNC      = 4'd1;
    localparam err_code_t ERR_HEAD0     = 4'd3;
    localparam err_code_t ERR_HEAD1     = 4'd4;
    localparam err_code_t ERR_FILE_END  = 4'd5;
    localparam err_code_t ERR_FRAME_NUM = 4'd6;
    localparam err_code_t ERR_ODD_LEN   = 4'd7;
    localparam err_code_t ERR_DATA      = 4'd8;
    localparam err_code_t ERR_CSUM      = 4'd9;
    localparam err_code_t ERR_EOF       = 4'd10;
    localparam err_code_t ERR_KCHAR     = 4'd11;

endpackage

`default_nettype wire

/* src/lchk_settings.svh */
// shared constants for the four-lane link checker
// rx words follow the TLK2711 order, the msb byte sits on rxd[15:8]
// the apb map assumes byte addresses and a 32-bit data bus
`ifndef LCHK_SETTINGS_SVH
`define LCHK_SETTINGS_SVH

`define LCHK_NUM_LANES      4
`define LCHK_WORD_W         16

// control words, k flags given as {msb, lsb}
`define LCHK_SYNC_WORD      16'hC5BC
`define LCHK_SYNC_KFLAGS    2'b01
`define LCHK_SOF_WORD       16'h5CFB
`define LCHK_EOF_WORD       16'hFDFE
`define LCHK_FRAME_KFLAGS   2'b11

// fixed frame fields
`define LCHK_HEAD0          16'hEB90
`define LCHK_HEAD1          16'hE116
`define LCHK_FILE_END       16'h8101

// apb register map
`define LCHK_APB_AW         8
`define LCHK_ADDR_CTRL      8'h00
`define LCHK_ADDR_CLEAR     8'h04
`define LCHK_ADDR_LANE_BASE 8'h20
`define LCHK_LANE_STRIDE    8'h10
`define LCHK_OFF_GOOD       8'h0
`define LCHK_OFF_ERRS       8'h4
`define LCHK_OFF_LAST       8'h8

`endif
